/* hdl/slink_attr_consts.svh */
`ifndef SLINK_ATTR_CONSTS_SVH
`define SLINK_ATTR_CONSTS_SVH

`define SLINK_ATTR_WORD_W 16
// max_txs through sync_freq
`define SLINK_ATTR_NUM 11

// log2 of the lane counts
`define SLINK_ATTR_NUM_TX_LANES_CLOG2 2
`define SLINK_ATTR_NUM_RX_LANES_CLOG2 2

// attribute addresses
`define SLINK_ATTR_ADDR_MAX_TXS       16'h0000
`define SLINK_ATTR_ADDR_MAX_RXS       16'h0001
`define SLINK_ATTR_ADDR_ACTIVE_TXS    16'h0002
`define SLINK_ATTR_ADDR_ACTIVE_RXS    16'h0003
`define SLINK_ATTR_ADDR_HARD_RESET_US 16'h0008
`define SLINK_ATTR_ADDR_PX_CLK_TRAIL  16'h0010
`define SLINK_ATTR_ADDR_P1_TS1_TX     16'h0020
`define SLINK_ATTR_ADDR_P1_TS1_RX     16'h0021
`define SLINK_ATTR_ADDR_P1_TS2_TX     16'h0022
`define SLINK_ATTR_ADDR_P1_TS2_RX     16'h0023
`define SLINK_ATTR_ADDR_SYNC_FREQ     16'h0030

// stored widths
`define SLINK_ATTR_WIDTH_MAX_TXS       3
`define SLINK_ATTR_WIDTH_MAX_RXS       3
`define SLINK_ATTR_WIDTH_ACTIVE_TXS    3
`define SLINK_ATTR_WIDTH_ACTIVE_RXS    3
`define SLINK_ATTR_WIDTH_HARD_RESET_US 10
`define SLINK_ATTR_WIDTH_PX_CLK_TRAIL  8
`define SLINK_ATTR_WIDTH_P1_TS1_TX     16
`define SLINK_ATTR_WIDTH_P1_TS1_RX     16
`define SLINK_ATTR_WIDTH_P1_TS2_TX     16
`define SLINK_ATTR_WIDTH_P1_TS2_RX     16
`define SLINK_ATTR_WIDTH_SYNC_FREQ     8

// reset values, also restored by hard reset
`define SLINK_ATTR_RESET_MAX_TXS       `SLINK_ATTR_NUM_TX_LANES_CLOG2
`define SLINK_ATTR_RESET_MAX_RXS       `SLINK_ATTR_NUM_RX_LANES_CLOG2
`define SLINK_ATTR_RESET_ACTIVE_TXS    `SLINK_ATTR_NUM_TX_LANES_CLOG2
`define SLINK_ATTR_RESET_ACTIVE_RXS    `SLINK_ATTR_NUM_RX_LANES_CLOG2
`define SLINK_ATTR_RESET_HARD_RESET_US 100
`define SLINK_ATTR_RESET_PX_CLK_TRAIL  32
`define SLINK_ATTR_RESET_P1_TS1_TX     16
`define SLINK_ATTR_RESET_P1_TS1_RX     16
`define SLINK_ATTR_RESET_P1_TS2_TX     4
`define SLINK_ATTR_RESET_P1_TS2_RX     4
`define SLINK_ATTR_RESET_SYNC_FREQ     15

`endif

/* hdl/slink_attr_pkg.sv */
`include "slink_attr_consts.svh"

package slink_attr_pkg;

  // one identifier per attribute, in address order
  typedef enum logic [3:0] {
    ATTR_MAX_TXS,
    ATTR_MAX_RXS,
    ATTR_ACTIVE_TXS,
    ATTR_ACTIVE_RXS,
    ATTR_HARD_RESET_US,
    ATTR_PX_CLK_TRAIL,
    ATTR_P1_TS1_TX,
    ATTR_P1_TS1_RX,
    ATTR_P1_TS2_TX,
    ATTR_P1_TS2_RX,
    ATTR_SYNC_FREQ
  } attr_id_t;

  typedef logic [`SLINK_ATTR_WORD_W-1:0] attr_word_t;

  // indexed by attr_id_t
  typedef attr_word_t [`SLINK_ATTR_NUM-1:0] attr_words_t;

endpackage

/* hdl/slink_attr_addr_decode.sv */
`include "slink_attr_consts.svh"

module slink_attr_addr_decode
  import slink_attr_pkg::*;
(
  input  logic [`SLINK_ATTR_WORD_W-1:0] addr,
  output attr_id_t                      attr_id,
  output logic                          hit
);

  always_comb begin
    hit     = 1'b1;
    attr_id = ATTR_MAX_TXS;
    case (addr)
      `SLINK_ATTR_ADDR_MAX_TXS:       attr_id = ATTR_MAX_TXS;
      `SLINK_ATTR_ADDR_MAX_RXS:       attr_id = ATTR_MAX_RXS;
      `SLINK_ATTR_ADDR_ACTIVE_TXS:    attr_id = ATTR_ACTIVE_TXS;
      `SLINK_ATTR_ADDR_ACTIVE_RXS:    attr_id = ATTR_ACTIVE_RXS;
      `SLINK_ATTR_ADDR_HARD_RESET_US: attr_id = ATTR_HARD_RESET_US;
      `SLINK_ATTR_ADDR_PX_CLK_TRAIL:  attr_id = ATTR_PX_CLK_TRAIL;
      `SLINK_ATTR_ADDR_P1_TS1_TX:     attr_id = ATTR_P1_TS1_TX;
      `SLINK_ATTR_ADDR_P1_TS1_RX:     attr_id = ATTR_P1_TS1_RX;
      `SLINK_ATTR_ADDR_P1_TS2_TX:     attr_id = ATTR_P1_TS2_TX;
      `SLINK_ATTR_ADDR_P1_TS2_RX:     attr_id = ATTR_P1_TS2_RX;
      `SLINK_ATTR_ADDR_SYNC_FREQ:     attr_id = ATTR_SYNC_FREQ;
      // unmapped, id is don't care
      default:                        hit = 1'b0;
    endcase
  end

endmodule

/* hdl/slink_attr_write_select.sv */
`include "slink_attr_consts.svh"

module slink_attr_write_select
  import slink_attr_pkg::*;
(
  input  logic                      link_hit,
  input  logic                      link_update,
  input  logic                      app_hit,
  input  logic                      app_update,
  input  logic                      sw_hit,
  input  logic                      sw_update,
  input  attr_id_t                  link_id,
  input  attr_id_t                  app_id,
  input  attr_id_t                  sw_id,
  input  attr_word_t                link_data,
  input  attr_word_t                app_data,
  input  attr_word_t                sw_data,
  output logic [`SLINK_ATTR_NUM-1:0] wr_en,
  output attr_words_t               wr_data
);

  logic link_wr;
  logic app_wr;
  logic sw_wr;

  // strobe only counts at a mapped address
  assign link_wr = link_update & link_hit;
  assign app_wr  = app_update & app_hit;
  assign sw_wr   = sw_update & sw_hit;

  // lowest priority first, later matches override
  always_comb begin
    for (int i = 0; i < `SLINK_ATTR_NUM; i++) begin
      wr_en[i]   = 1'b0;
      wr_data[i] = '0;
      if (sw_wr && (sw_id == attr_id_t'(i))) begin
        wr_en[i]   = 1'b1;
        wr_data[i] = sw_data;
      end
      if (app_wr && (app_id == attr_id_t'(i))) begin
        wr_en[i]   = 1'b1;
        wr_data[i] = app_data;
      end
      if (link_wr && (link_id == attr_id_t'(i))) begin
        wr_en[i]   = 1'b1;
        wr_data[i] = link_data;
      end
    end
  end

endmodule

/* hdl/slink_attr_bank.sv */
`include "slink_attr_consts.svh"

module slink_attr_bank
  import slink_attr_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     hard_reset_cond,
  input  logic                                     effective_update,
  input  logic [`SLINK_ATTR_NUM-1:0]               wr_en,
  input  attr_words_t                              wr_data,
  output attr_words_t                              shadow,
  output logic [`SLINK_ATTR_WIDTH_MAX_TXS-1:0]       attr_max_txs,
  output logic [`SLINK_ATTR_WIDTH_MAX_RXS-1:0]       attr_max_rxs,
  output logic [`SLINK_ATTR_WIDTH_ACTIVE_TXS-1:0]    attr_active_txs,
  output logic [`SLINK_ATTR_WIDTH_ACTIVE_RXS-1:0]    attr_active_rxs,
  output logic [`SLINK_ATTR_WIDTH_HARD_RESET_US-1:0] attr_hard_reset_us,
  output logic [`SLINK_ATTR_WIDTH_PX_CLK_TRAIL-1:0]  attr_px_clk_trail,
  output logic [`SLINK_ATTR_WIDTH_P1_TS1_TX-1:0]     attr_p1_ts1_tx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS1_RX-1:0]     attr_p1_ts1_rx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS2_TX-1:0]     attr_p1_ts2_tx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS2_RX-1:0]     attr_p1_ts2_rx,
  output logic [`SLINK_ATTR_WIDTH_SYNC_FREQ-1:0]     attr_sync_freq
);

  // highest index first
  localparam attr_words_t RESET_WORDS = {
    attr_word_t'(`SLINK_ATTR_RESET_SYNC_FREQ),
    attr_word_t'(`SLINK_ATTR_RESET_P1_TS2_RX),
    attr_word_t'(`SLINK_ATTR_RESET_P1_TS2_TX),
    attr_word_t'(`SLINK_ATTR_RESET_P1_TS1_RX),
    attr_word_t'(`SLINK_ATTR_RESET_P1_TS1_TX),
    attr_word_t'(`SLINK_ATTR_RESET_PX_CLK_TRAIL),
    attr_word_t'(`SLINK_ATTR_RESET_HARD_RESET_US),
    attr_word_t'(`SLINK_ATTR_RESET_ACTIVE_RXS),
    attr_word_t'(`SLINK_ATTR_RESET_ACTIVE_TXS),
    attr_word_t'(`SLINK_ATTR_RESET_MAX_RXS),
    attr_word_t'(`SLINK_ATTR_RESET_MAX_TXS)
  };

  localparam attr_words_t WIDTH_MASK = {
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_SYNC_FREQ) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_P1_TS2_RX) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_P1_TS2_TX) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_P1_TS1_RX) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_P1_TS1_TX) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_PX_CLK_TRAIL) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_HARD_RESET_US) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_ACTIVE_RXS) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_ACTIVE_TXS) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_MAX_RXS) - 1),
    attr_word_t'((1 << `SLINK_ATTR_WIDTH_MAX_TXS) - 1)
  };

  // lane capability is fixed
  localparam logic [`SLINK_ATTR_NUM-1:0] RO_MASK =
    `SLINK_ATTR_NUM'((1 << ATTR_MAX_TXS) | (1 << ATTR_MAX_RXS));

  attr_words_t effective;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shadow    <= RESET_WORDS;
      effective <= RESET_WORDS;
    end else if (hard_reset_cond) begin
      shadow    <= RESET_WORDS;
      effective <= RESET_WORDS;
    end else begin
      // effective takes the shadow from before this edge
      if (effective_update) begin
        effective <= shadow;
      end
      for (int i = 0; i < `SLINK_ATTR_NUM; i++) begin
        if (wr_en[i] && !RO_MASK[i]) begin
          shadow[i] <= wr_data[i] & WIDTH_MASK[i];
        end
      end
    end
  end

  assign attr_max_txs       = effective[ATTR_MAX_TXS][`SLINK_ATTR_WIDTH_MAX_TXS-1:0];
  assign attr_max_rxs       = effective[ATTR_MAX_RXS][`SLINK_ATTR_WIDTH_MAX_RXS-1:0];
  assign attr_active_txs    = effective[ATTR_ACTIVE_TXS][`SLINK_ATTR_WIDTH_ACTIVE_TXS-1:0];
  assign attr_active_rxs    = effective[ATTR_ACTIVE_RXS][`SLINK_ATTR_WIDTH_ACTIVE_RXS-1:0];
  assign attr_hard_reset_us =
    effective[ATTR_HARD_RESET_US][`SLINK_ATTR_WIDTH_HARD_RESET_US-1:0];
  assign attr_px_clk_trail  = effective[ATTR_PX_CLK_TRAIL][`SLINK_ATTR_WIDTH_PX_CLK_TRAIL-1:0];
  assign attr_p1_ts1_tx     = effective[ATTR_P1_TS1_TX][`SLINK_ATTR_WIDTH_P1_TS1_TX-1:0];
  assign attr_p1_ts1_rx     = effective[ATTR_P1_TS1_RX][`SLINK_ATTR_WIDTH_P1_TS1_RX-1:0];
  assign attr_p1_ts2_tx     = effective[ATTR_P1_TS2_TX][`SLINK_ATTR_WIDTH_P1_TS2_TX-1:0];
  assign attr_p1_ts2_rx     = effective[ATTR_P1_TS2_RX][`SLINK_ATTR_WIDTH_P1_TS2_RX-1:0];
  assign attr_sync_freq     = effective[ATTR_SYNC_FREQ][`SLINK_ATTR_WIDTH_SYNC_FREQ-1:0];

endmodule

/* hdl/slink_attr_read_mux.sv */
module slink_attr_read_mux
  import slink_attr_pkg::*;
(
  input  attr_id_t    attr_id,
  input  logic        hit,
  input  attr_words_t shadow,
  output attr_word_t  data_read
);

  // shadow words are already masked, so upper bits come out as zero
  always_comb begin
    if (hit) begin
      data_read = shadow[attr_id];
    end else begin
      data_read = '0;
    end
  end

endmodule

/* hdl/slink_attr_top.sv */
`include "slink_attr_consts.svh"

module slink_attr_top
  import slink_attr_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     hard_reset_cond,
  input  logic                                     effective_update,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              link_attr_addr,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              link_attr_data,
  input  logic                                     link_shadow_update,
  output logic [`SLINK_ATTR_WORD_W-1:0]              link_attr_data_read,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              app_attr_addr,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              app_attr_data,
  input  logic                                     app_shadow_update,
  output logic [`SLINK_ATTR_WORD_W-1:0]              app_attr_data_read,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              sw_attr_addr,
  input  logic [`SLINK_ATTR_WORD_W-1:0]              sw_attr_data,
  input  logic                                     sw_shadow_update,
  output logic [`SLINK_ATTR_WORD_W-1:0]              sw_attr_data_read,
  output logic [`SLINK_ATTR_WIDTH_MAX_TXS-1:0]       attr_max_txs,
  output logic [`SLINK_ATTR_WIDTH_MAX_RXS-1:0]       attr_max_rxs,
  output logic [`SLINK_ATTR_WIDTH_ACTIVE_TXS-1:0]    attr_active_txs,
  output logic [`SLINK_ATTR_WIDTH_ACTIVE_RXS-1:0]    attr_active_rxs,
  output logic [`SLINK_ATTR_WIDTH_HARD_RESET_US-1:0] attr_hard_reset_us,
  output logic [`SLINK_ATTR_WIDTH_PX_CLK_TRAIL-1:0]  attr_px_clk_trail,
  output logic [`SLINK_ATTR_WIDTH_P1_TS1_TX-1:0]     attr_p1_ts1_tx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS1_RX-1:0]     attr_p1_ts1_rx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS2_TX-1:0]     attr_p1_ts2_tx,
  output logic [`SLINK_ATTR_WIDTH_P1_TS2_RX-1:0]     attr_p1_ts2_rx,
  output logic [`SLINK_ATTR_WIDTH_SYNC_FREQ-1:0]     attr_sync_freq
);

  attr_id_t                   link_id;
  attr_id_t                   app_id;
  attr_id_t                   sw_id;
  logic                       link_hit;
  logic                       app_hit;
  logic                       sw_hit;
  logic [`SLINK_ATTR_NUM-1:0] wr_en;
  attr_words_t                wr_data;
  attr_words_t                shadow;

  // one decoder per agent
  slink_attr_addr_decode u_link_decode (
    .addr    ( link_attr_addr ),
    .attr_id ( link_id        ),
    .hit     ( link_hit       ));

  slink_attr_addr_decode u_app_decode (
    .addr    ( app_attr_addr  ),
    .attr_id ( app_id         ),
    .hit     ( app_hit        ));

  slink_attr_addr_decode u_sw_decode (
    .addr    ( sw_attr_addr   ),
    .attr_id ( sw_id          ),
    .hit     ( sw_hit         ));

  slink_attr_write_select u_write_select (
    .link_hit    ( link_hit           ),
    .link_update ( link_shadow_update ),
    .app_hit     ( app_hit            ),
    .app_update  ( app_shadow_update  ),
    .sw_hit      ( sw_hit             ),
    .sw_update   ( sw_shadow_update   ),
    .link_id     ( link_id            ),
    .app_id      ( app_id             ),
    .sw_id       ( sw_id              ),
    .link_data   ( link_attr_data     ),
    .app_data    ( app_attr_data      ),
    .sw_data     ( sw_attr_data       ),
    .wr_en       ( wr_en              ),
    .wr_data     ( wr_data            ));

  slink_attr_bank u_bank (
    .clk                ( clk                ),
    .reset              ( reset              ),
    .hard_reset_cond    ( hard_reset_cond    ),
    .effective_update   ( effective_update   ),
    .wr_en              ( wr_en              ),
    .wr_data            ( wr_data            ),
    .shadow             ( shadow             ),
    .attr_max_txs       ( attr_max_txs       ),
    .attr_max_rxs       ( attr_max_rxs       ),
    .attr_active_txs    ( attr_active_txs    ),
    .attr_active_rxs    ( attr_active_rxs    ),
    .attr_hard_reset_us ( attr_hard_reset_us ),
    .attr_px_clk_trail  ( attr_px_clk_trail  ),
    .attr_p1_ts1_tx     ( attr_p1_ts1_tx     ),
    .attr_p1_ts1_rx     ( attr_p1_ts1_rx     ),
    .attr_p1_ts2_tx     ( attr_p1_ts2_tx     ),
    .attr_p1_ts2_rx     ( attr_p1_ts2_rx     ),
    .attr_sync_freq     ( attr_sync_freq     ));

  // read ports see the shadow, not the effective copy
  slink_attr_read_mux u_link_read (
    .attr_id   ( link_id             ),
    .hit       ( link_hit            ),
    .shadow    ( shadow              ),
    .data_read ( link_attr_data_read ));

  slink_attr_read_mux u_app_read (
    .attr_id   ( app_id              ),
    .hit       ( app_hit             ),
    .shadow    ( shadow              ),
    .data_read ( app_attr_data_read  ));

  slink_attr_read_mux u_sw_read (
    .attr_id   ( sw_id               ),
    .hit       ( sw_hit              ),
    .shadow    ( shadow              ),
    .data_read ( sw_attr_data_read   ));

endmodule

/* sim/slink_attr_tb.sv */
`include "slink_attr_consts.svh"

module slink_attr_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM = `SLINK_ATTR_NUM;

  logic clk;
  logic reset;
  logic hard_reset_cond;
  logic effective_update;
  // agent 0 is link, 1 is app, 2 is sw
  logic [2:0][15:0]     addr;
  logic [2:0][15:0]     data;
  logic [2:0]           upd;
  logic [2:0][15:0]     rd;
  logic [NUM-1:0][15:0] eff_out;
  integer               seed;

  // reference model state
  logic [15:0] m_shadow [NUM];
  logic [15:0] m_eff [NUM];

  logic [15:0] addr_tab [NUM] = '{
    `SLINK_ATTR_ADDR_MAX_TXS, `SLINK_ATTR_ADDR_MAX_RXS, `SLINK_ATTR_ADDR_ACTIVE_TXS,
    `SLINK_ATTR_ADDR_ACTIVE_RXS, `SLINK_ATTR_ADDR_HARD_RESET_US, `SLINK_ATTR_ADDR_PX_CLK_TRAIL,
    `SLINK_ATTR_ADDR_P1_TS1_TX, `SLINK_ATTR_ADDR_P1_TS1_RX, `SLINK_ATTR_ADDR_P1_TS2_TX,
    `SLINK_ATTR_ADDR_P1_TS2_RX, `SLINK_ATTR_ADDR_SYNC_FREQ};
  int width_tab [NUM] = '{
    `SLINK_ATTR_WIDTH_MAX_TXS, `SLINK_ATTR_WIDTH_MAX_RXS, `SLINK_ATTR_WIDTH_ACTIVE_TXS,
    `SLINK_ATTR_WIDTH_ACTIVE_RXS, `SLINK_ATTR_WIDTH_HARD_RESET_US,
    `SLINK_ATTR_WIDTH_PX_CLK_TRAIL, `SLINK_ATTR_WIDTH_P1_TS1_TX, `SLINK_ATTR_WIDTH_P1_TS1_RX,
    `SLINK_ATTR_WIDTH_P1_TS2_TX, `SLINK_ATTR_WIDTH_P1_TS2_RX, `SLINK_ATTR_WIDTH_SYNC_FREQ};
  logic [15:0] reset_tab [NUM] = '{
    16'(`SLINK_ATTR_RESET_MAX_TXS), 16'(`SLINK_ATTR_RESET_MAX_RXS),
    16'(`SLINK_ATTR_RESET_ACTIVE_TXS), 16'(`SLINK_ATTR_RESET_ACTIVE_RXS),
    16'(`SLINK_ATTR_RESET_HARD_RESET_US), 16'(`SLINK_ATTR_RESET_PX_CLK_TRAIL),
    16'(`SLINK_ATTR_RESET_P1_TS1_TX), 16'(`SLINK_ATTR_RESET_P1_TS1_RX),
    16'(`SLINK_ATTR_RESET_P1_TS2_TX), 16'(`SLINK_ATTR_RESET_P1_TS2_RX),
    16'(`SLINK_ATTR_RESET_SYNC_FREQ)};

  slink_attr_top u_dut (
    .clk                 ( clk              ),
    .reset               ( reset            ),
    .hard_reset_cond     ( hard_reset_cond  ),
    .effective_update    ( effective_update ),
    .link_attr_addr      ( addr[0]          ),
    .link_attr_data      ( data[0]          ),
    .link_shadow_update  ( upd[0]           ),
    .link_attr_data_read ( rd[0]            ),
    .app_attr_addr       ( addr[1]          ),
    .app_attr_data       ( data[1]          ),
    .app_shadow_update   ( upd[1]           ),
    .app_attr_data_read  ( rd[1]            ),
    .sw_attr_addr        ( addr[2]          ),
    .sw_attr_data        ( data[2]          ),
    .sw_shadow_update    ( upd[2]           ),
    .sw_attr_data_read   ( rd[2]            ),
    .attr_max_txs        ( eff_out[0][`SLINK_ATTR_WIDTH_MAX_TXS-1:0]        ),
    .attr_max_rxs        ( eff_out[1][`SLINK_ATTR_WIDTH_MAX_RXS-1:0]        ),
    .attr_active_txs     ( eff_out[2][`SLINK_ATTR_WIDTH_ACTIVE_TXS-1:0]     ),
    .attr_active_rxs     ( eff_out[3][`SLINK_ATTR_WIDTH_ACTIVE_RXS-1:0]     ),
    .attr_hard_reset_us  ( eff_out[4][`SLINK_ATTR_WIDTH_HARD_RESET_US-1:0]  ),
    .attr_px_clk_trail   ( eff_out[5][`SLINK_ATTR_WIDTH_PX_CLK_TRAIL-1:0]   ),
    .attr_p1_ts1_tx      ( eff_out[6][`SLINK_ATTR_WIDTH_P1_TS1_TX-1:0]      ),
    .attr_p1_ts1_rx      ( eff_out[7][`SLINK_ATTR_WIDTH_P1_TS1_RX-1:0]      ),
    .attr_p1_ts2_tx      ( eff_out[8][`SLINK_ATTR_WIDTH_P1_TS2_TX-1:0]      ),
    .attr_p1_ts2_rx      ( eff_out[9][`SLINK_ATTR_WIDTH_P1_TS2_RX-1:0]      ),
    .attr_sync_freq      ( eff_out[10][`SLINK_ATTR_WIDTH_SYNC_FREQ-1:0]     ));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] mask_of(input int i);
    return 16'((32'd1 << width_tab[i]) - 32'd1);
  endfunction

  function automatic int find_attr(input logic [15:0] a);
    for (int i = 0; i < NUM; i++) begin
      if (addr_tab[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_word(input string name, input string port, input logic [15:0] exp,
                            input logic [15:0] act);
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected 0x%04h, actual 0x%04h", name, port, exp, act);
      $display("Verification failed");
      $fatal(1, "wrong value on %s", port);
    end
  endtask

  // settle, then compare every read port and effective output
  task automatic check_state(input string name);
    int idx;
    #5;
    for (int a = 0; a < 3; a++) begin
      idx = find_attr(addr[a]);
      check_word(name, $sformatf("read port %0d", a), (idx < 0) ? 16'h0 : m_shadow[idx],
                 rd[a]);
    end
    for (int i = 0; i < NUM; i++) begin
      check_word(name, $sformatf("effective %0d", i), m_eff[i], eff_out[i] & mask_of(i));
    end
  endtask

  // model the edge, then release the one-cycle inputs
  task automatic clock_edge();
    logic [15:0] nxt_sh [NUM];
    logic [15:0] nxt_eff [NUM];
    int          w;
    nxt_sh  = m_shadow;
    nxt_eff = m_eff;
    if (hard_reset_cond) begin
      nxt_sh  = reset_tab;
      nxt_eff = reset_tab;
    end else begin
      if (effective_update) begin
        nxt_eff = m_shadow;
      end
      for (int i = 0; i < NUM; i++) begin
        w = -1;
        // scan sw first so that app and then link take over
        for (int a = 2; a >= 0; a--) begin
          if (upd[a] && addr[a] == addr_tab[i]) begin
            w = a;
          end
        end
        // max_txs and max_rxs are read-only
        if (w >= 0 && i > 1) begin
          nxt_sh[i] = data[w] & mask_of(i);
        end
      end
    end
    @(posedge clk);
    #2;
    m_shadow         = nxt_sh;
    m_eff            = nxt_eff;
    upd              = '0;
    effective_update = 1'b0;
    hard_reset_cond  = 1'b0;
  endtask

  task automatic drive_write(input int a, input int i, input logic [15:0] value);
    addr[a] = addr_tab[i];
    data[a] = value;
    upd[a]  = 1'b1;
  endtask

  task automatic sweep_reads(input string name);
    for (int i = 0; i < NUM; i++) begin
      addr = {3{addr_tab[i]}};
      check_state(name);
      clock_edge();
    end
  endtask

  initial begin
    for (int n = 0; n < 5000; n++) begin
      @(posedge clk);
    end
    $display("Timeout: the test did not finish within 5000 clock cycles");
    $display("Verification failed");
    $fatal(1, "simulation timeout");
  end

  initial begin
    int          k;
    logic [15:0] v;
    seed             = 34;
    reset            = 1'b1;
    hard_reset_cond  = 1'b0;
    effective_update = 1'b0;
    addr             = '0;
    data             = '0;
    upd              = '0;
    m_shadow         = reset_tab;
    m_eff            = reset_tab;
    for (int n = 0; n < 10; n++) begin
      @(posedge clk);
    end
    #2;
    reset = 1'b0;
    sweep_reads("reset_values");

    for (int a = 0; a < 3; a++) begin
      for (int i = 0; i < NUM; i++) begin
        drive_write(a, i, 16'($random(seed)));
        clock_edge();
        check_state("agent_write");
      end
    end
    // a write next to the copy waits for the following copy
    effective_update = 1'b1;
    drive_write(0, NUM - 1, 16'($random(seed)));
    clock_edge();
    check_state("effective_copy");
    effective_update = 1'b1;
    clock_edge();
    check_state("effective_copy");

    k = 2 + ({$random(seed)} % (NUM - 2));
    v = 16'($random(seed));
    // low bits differ per agent so the winner shows at any width
    for (int a = 0; a < 3; a++) begin
      drive_write(a, k, v ^ 16'(a + 1));
    end
    clock_edge();
    check_state("priority_all");
    v = 16'($random(seed));
    drive_write(1, k, v ^ 16'h0001);
    drive_write(2, k, v ^ 16'h0002);
    clock_edge();
    check_state("priority_app_sw");
    drive_write(0, 2, 16'($random(seed)));
    drive_write(1, 5, 16'($random(seed)));
    drive_write(2, NUM - 1, 16'($random(seed)));
    clock_edge();
    check_state("parallel_writes");

    addr = {16'hffff, 16'h00ff, 16'h0004};
    data = {16'($random(seed)), 16'($random(seed)), 16'($random(seed))};
    upd  = 3'b111;
    check_state("unmapped");
    clock_edge();
    check_state("unmapped");
    sweep_reads("unmapped");

    for (int n = 0; n < 20; n++) begin
      for (int a = 0; a < 3; a++) begin
        addr[a] = addr_tab[{$random(seed)} % NUM];
        data[a] = 16'($random(seed));
      end
      upd              = 3'($random(seed));
      effective_update = 1'($random(seed));
      clock_edge();
      check_state("random_writes");
    end
    effective_update = 1'b1;
    clock_edge();
    check_state("random_writes");
    for (int a = 0; a < 3; a++) begin
      drive_write(a, 4 + a, 16'($random(seed)));
    end
    effective_update = 1'b1;
    hard_reset_cond  = 1'b1;
    clock_edge();
    check_state("hard_reset");
    sweep_reads("hard_reset");

    $display("Verification passed");
    $finish;
  end

endmodule

/* slink_attr.f */
+incdir+hdl
hdl/slink_attr_pkg.sv
hdl/slink_attr_addr_decode.sv
hdl/slink_attr_write_select.sv
hdl/slink_attr_bank.sv
hdl/slink_attr_read_mux.sv
hdl/slink_attr_top.sv
sim/slink_attr_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the slink_attr testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f slink_attr.f --top-module slink_attr_tb -o slink_attr_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit $status
fi

./obj_dir/slink_attr_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
